/* include/car_video_settings.svh */
`ifndef CAR_VIDEO_SETTINGS_SVH
`define CAR_VIDEO_SETTINGS_SVH

`define WORLD_BITS      18
`define COUNT_BITS      12

// 720p frame, positive sync
`define H_ACTIVE        1280
`define H_FRONT         110
`define H_SYNC          40
`define H_BACK          220
`define V_ACTIVE        720
`define V_FRONT         5
`define V_SYNC          5
`define V_BACK          20

`define CAMERA_STEP     5  // world units per frame
`define EDGE_THICKNESS  3  // outline width in world units

// scene register map
`define ADDR_CAMERA_X   8'h00
`define ADDR_CAMERA_Y   8'h04
`define ADDR_CAR_X      8'h08
`define ADDR_CAR_Y      8'h0C
`define ADDR_BODY_W     8'h10
`define ADDR_BODY_H     8'h14
`define ADDR_WHEEL_R    8'h18
`define ADDR_BG_COLOR   8'h1C

`define RST_CAMERA_X    0
`define RST_CAMERA_Y    0
`define RST_CAR_X       500
`define RST_CAR_Y       300
`define RST_BODY_W      200
`define RST_BODY_H      100
`define RST_WHEEL_R     25
`define RST_BG_COLOR    4'hF

`endif

/* hdl/car_video_pkg.sv */
`default_nettype none
`include "car_video_settings.svh"

package car_video_pkg;

  typedef logic signed [`WORLD_BITS-1:0] world_coord_t;
  typedef logic [`COUNT_BITS-1:0] screen_count_t;
  typedef logic [3:0] color_idx_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef logic [9:0] tmds_word_t;
  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // palette indices
  localparam color_idx_t COLOR_BLACK  = 4'h0;
  localparam color_idx_t COLOR_GRAY   = 4'h1;
  localparam color_idx_t COLOR_WHITE  = 4'h2;
  localparam color_idx_t COLOR_RED    = 4'h3;
  localparam color_idx_t COLOR_PINK   = 4'h4;
  localparam color_idx_t COLOR_DBROWN = 4'h5;
  localparam color_idx_t COLOR_BROWN  = 4'h6;
  localparam color_idx_t COLOR_ORANGE = 4'h7;
  localparam color_idx_t COLOR_YELLOW = 4'h8;
  localparam color_idx_t COLOR_DGREEN = 4'h9;
  localparam color_idx_t COLOR_GREEN  = 4'hA;
  localparam color_idx_t COLOR_LGREEN = 4'hB;
  localparam color_idx_t COLOR_PURPLE = 4'hC;
  localparam color_idx_t COLOR_DBLUE  = 4'hD;
  localparam color_idx_t COLOR_BLUE   = 4'hE;
  localparam color_idx_t COLOR_LBLUE  = 4'hF;

endpackage
`default_nettype wire

/* hdl/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none
`include "car_video_settings.svh"

module video_timing #(
  parameter int H_ACTIVE = `H_ACTIVE,
  parameter int H_FRONT  = `H_FRONT,
  parameter int H_SYNC   = `H_SYNC,
  parameter int H_BACK   = `H_BACK,
  parameter int V_ACTIVE = `V_ACTIVE,
  parameter int V_FRONT  = `V_FRONT,
  parameter int V_SYNC   = `V_SYNC,
  parameter int V_BACK   = `V_BACK
) (
  input wire clk_100mhz,
  input wire sys_rst,
  output car_video_pkg::screen_count_t hcount,
  output car_video_pkg::screen_count_t vcount,
  output logic hsync,
  output logic vsync,
  output logic active,
  output logic new_frame
);
  import car_video_pkg::*;

  localparam screen_count_t H_LAST   = screen_count_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
  localparam screen_count_t V_LAST   = screen_count_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
  localparam screen_count_t HS_START = screen_count_t'(H_ACTIVE + H_FRONT);
  localparam screen_count_t HS_END   = screen_count_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam screen_count_t VS_START = screen_count_t'(V_ACTIVE + V_FRONT);
  localparam screen_count_t VS_END   = screen_count_t'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam screen_count_t H_VIS    = screen_count_t'(H_ACTIVE);
  localparam screen_count_t V_VIS    = screen_count_t'(V_ACTIVE);

  // pixel and line counters
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      hcount <= '0;
      vcount <= '0;
    end else if (hcount == H_LAST) begin
      hcount <= '0;
      vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1; // next line or wrap frame
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  assign hsync     = (hcount >= HS_START) && (hcount < HS_END);
  assign vsync     = (vcount >= VS_START) && (vcount < VS_END);
  assign active    = (hcount < H_VIS) && (vcount < V_VIS);
  assign new_frame = (hcount == H_VIS) && (vcount == V_VIS); // first blanking pixel of frame

endmodule
`default_nettype wire

/* hdl/scene_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "car_video_settings.svh"

module scene_regs (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire car_video_pkg::apb_addr_t paddr,
  input wire car_video_pkg::apb_data_t pwdata,
  input wire [3:0] btn,
  input wire new_frame,
  output car_video_pkg::apb_data_t prdata,
  output logic pready,
  output logic pslverr,
  output car_video_pkg::world_coord_t camera_x,
  output car_video_pkg::world_coord_t camera_y,
  output car_video_pkg::world_coord_t car_x,
  output car_video_pkg::world_coord_t car_y,
  output car_video_pkg::world_coord_t body_w,
  output car_video_pkg::world_coord_t body_h,
  output car_video_pkg::world_coord_t wheel_r,
  output car_video_pkg::color_idx_t bg_color
);
  import car_video_pkg::*;

  localparam world_coord_t STEP = world_coord_t'(`CAMERA_STEP);

  function automatic apb_data_t sext(input world_coord_t v);
    return {{(32-`WORLD_BITS){v[`WORLD_BITS-1]}}, v};
  endfunction

  logic access;
  logic addr_ok;
  logic wr_en;
  world_coord_t wdata_w;
  apb_data_t rd_word;

  assign access  = psel && penable;        // access phase
  assign wr_en   = access && pwrite && addr_ok;
  assign wdata_w = world_coord_t'(pwdata[`WORLD_BITS-1:0]);
  assign pready  = 1'b1;                   // no wait states
  assign pslverr = access && !addr_ok;

  //////////////////////////////////////////////////////////////////////
  // address decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    rd_word = '0;
    case (paddr)
      `ADDR_CAMERA_X: rd_word = sext(camera_x);
      `ADDR_CAMERA_Y: rd_word = sext(camera_y);
      `ADDR_CAR_X:    rd_word = sext(car_x);
      `ADDR_CAR_Y:    rd_word = sext(car_y);
      `ADDR_BODY_W:   rd_word = sext(body_w);
      `ADDR_BODY_H:   rd_word = sext(body_h);
      `ADDR_WHEEL_R:  rd_word = sext(wheel_r);
      `ADDR_BG_COLOR: rd_word = {28'd0, bg_color};
      default:        addr_ok = 1'b0;
    endcase
  end

  assign prdata = (access && !pwrite) ? rd_word : '0;

  //////////////////////////////////////////////////////////////////////
  // scene registers, apb write overrides a pan in the same cycle
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      camera_x <= world_coord_t'(`RST_CAMERA_X);
      camera_y <= world_coord_t'(`RST_CAMERA_Y);
      car_x    <= world_coord_t'(`RST_CAR_X);
      car_y    <= world_coord_t'(`RST_CAR_Y);
      body_w   <= world_coord_t'(`RST_BODY_W);
      body_h   <= world_coord_t'(`RST_BODY_H);
      wheel_r  <= world_coord_t'(`RST_WHEEL_R);
      bg_color <= `RST_BG_COLOR;
    end else begin
      if (new_frame) begin
        if (btn[3]) camera_x <= camera_x - STEP;
        else if (btn[2]) camera_x <= camera_x + STEP;
        else if (btn[1]) camera_y <= camera_y - STEP;
        else if (btn[0]) camera_y <= camera_y + STEP;
      end
      if (wr_en) begin
        case (paddr)
          `ADDR_CAMERA_X: camera_x <= wdata_w;
          `ADDR_CAMERA_Y: camera_y <= wdata_w;
          `ADDR_CAR_X:    car_x    <= wdata_w;
          `ADDR_CAR_Y:    car_y    <= wdata_w;
          `ADDR_BODY_W:   body_w   <= wdata_w;
          `ADDR_BODY_H:   body_h   <= wdata_w;
          `ADDR_WHEEL_R:  wheel_r  <= wdata_w;
          default:        bg_color <= pwdata[3:0]; // only bg_color left after decode
        endcase
      end
    end
  end

endmodule
`default_nettype wire

/* hdl/car_renderer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "car_video_settings.svh"

module car_renderer #(
  parameter int V_ACTIVE = `V_ACTIVE
) (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire car_video_pkg::screen_count_t hcount,
  input wire car_video_pkg::screen_count_t vcount,
  input wire hsync,
  input wire vsync,
  input wire active,
  input wire car_video_pkg::world_coord_t camera_x,
  input wire car_video_pkg::world_coord_t camera_y,
  input wire car_video_pkg::world_coord_t car_x,
  input wire car_video_pkg::world_coord_t car_y,
  input wire car_video_pkg::world_coord_t body_w,
  input wire car_video_pkg::world_coord_t body_h,
  input wire car_video_pkg::world_coord_t wheel_r,
  input wire car_video_pkg::color_idx_t bg_color,
  output car_video_pkg::rgb_t pixel_rgb,
  output logic hsync_out,
  output logic vsync_out,
  output logic active_out
);
  import car_video_pkg::*;

  localparam world_coord_t EDGE  = world_coord_t'(`EDGE_THICKNESS);
  localparam world_coord_t Y_TOP = world_coord_t'(V_ACTIVE - 1); // screen top in world y

  function automatic world_coord_t abs_w(input world_coord_t v);
    return (v < 0) ? -v : v;
  endfunction

  function automatic rgb_t palette(input color_idx_t idx);
    case (idx)
      COLOR_BLACK:  return 24'h000000;
      COLOR_GRAY:   return 24'h808080;
      COLOR_WHITE:  return 24'hFFFFFF;
      COLOR_RED:    return 24'hFF0000;
      COLOR_PINK:   return 24'hFFC0CB;
      COLOR_DBROWN: return 24'h654321;
      COLOR_BROWN:  return 24'h8B4513;
      COLOR_ORANGE: return 24'hFFA500;
      COLOR_YELLOW: return 24'hFFFF00;
      COLOR_DGREEN: return 24'h006400;
      COLOR_GREEN:  return 24'h00FF00;
      COLOR_LGREEN: return 24'h90EE90;
      COLOR_PURPLE: return 24'h800080;
      COLOR_DBLUE:  return 24'h00008B;
      COLOR_BLUE:   return 24'h0000FF;
      default:      return 24'h87CEEB; // light blue
    endcase
  endfunction

  world_coord_t world_x, world_y;
  world_coord_t dx, dx2, dy;     // offsets from wheel 1 / wheel 2 / car origin
  world_coord_t abs_dx, abs_dx2, abs_dy;
  logic in_wheel1, in_wheel2, in_body;
  logic wheel_edge, body_edge;
  color_idx_t pixel_idx;
  color_idx_t idx_q;
  logic [2:0] ctrl_q1, ctrl_q2;  // {active, vsync, hsync}

  //////////////////////////////////////////////////////////////////////
  // stage 1: screen to world, then classify
  assign world_x = world_coord_t'({1'b0, hcount}) + camera_x;
  assign world_y = Y_TOP - world_coord_t'({1'b0, vcount}) + camera_y; // y points up

  assign dx      = world_x - car_x;
  assign dx2     = world_x - (car_x + body_w);
  assign dy      = world_y - car_y;
  assign abs_dx  = abs_w(dx);
  assign abs_dx2 = abs_w(dx2);
  assign abs_dy  = abs_w(dy);

  assign in_wheel1 = (abs_dx < wheel_r) && (abs_dy < wheel_r);
  assign in_wheel2 = (abs_dx2 < wheel_r) && (abs_dy < wheel_r);
  assign in_body   = (dx >= 0) && (dx < body_w) && (dy >= 0) && (dy < body_h);

  // outline of whichever wheel claimed the pixel
  assign wheel_edge = (abs_dy >= wheel_r - EDGE) ||
                      (in_wheel1 ? (abs_dx >= wheel_r - EDGE) : (abs_dx2 >= wheel_r - EDGE));
  assign body_edge  = (dx < EDGE) || (dx >= body_w - EDGE) ||
                      (dy < EDGE) || (dy >= body_h - EDGE);

  always_comb begin
    if (in_wheel1 || in_wheel2) begin
      pixel_idx = wheel_edge ? COLOR_BLACK : COLOR_BROWN; // wheels sit on top of the body
    end else if (in_body) begin
      pixel_idx = body_edge ? COLOR_BLACK : COLOR_RED;
    end else begin
      pixel_idx = bg_color;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: palette lookup
  always_ff @(posedge clk_100mhz) begin
    idx_q     <= pixel_idx;
    pixel_rgb <= palette(idx_q);
  end

  // sync and active follow the pixel through both stages
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      ctrl_q1 <= '0;
      ctrl_q2 <= '0;
    end else begin
      ctrl_q1 <= {active, vsync, hsync};
      ctrl_q2 <= ctrl_q1;
    end
  end

  assign hsync_out  = ctrl_q2[0];
  assign vsync_out  = ctrl_q2[1];
  assign active_out = ctrl_q2[2];

endmodule
`default_nettype wire

/* hdl/tmds_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire [7:0] data,
  input wire [1:0] control,
  input wire video_enable,
  output car_video_pkg::tmds_word_t tmds
);
  import car_video_pkg::*;

  function automatic logic [3:0] count_ones(input logic [7:0] v);
    logic [3:0] n;
    n = '0;
    for (int i = 0; i < 8; i++) begin
      n = n + {3'd0, v[i]};
    end
    return n;
  endfunction

  logic [3:0] data_ones, qm_ones;
  logic use_xnor;
  logic [8:0] q_m;
  logic signed [4:0] balance;     // ones minus zeros of q_m[7:0]
  logic signed [4:0] disparity;   // running dc offset
  logic signed [4:0] next_disparity;
  tmds_word_t next_word;
  tmds_word_t ctrl_word;

  //////////////////////////////////////////////////////////////////////
  // transition minimizing
  assign data_ones = count_ones(data);
  assign use_xnor  = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data[0]);

  always_comb begin
    q_m[0] = data[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
    end
    q_m[8] = ~use_xnor; // 1 marks xor
  end

  assign qm_ones = count_ones(q_m[7:0]);
  assign balance = $signed(5'(qm_ones) - 5'(4'd8 - qm_ones));

  //////////////////////////////////////////////////////////////////////
  // dc balancing
  always_comb begin
    if ((disparity == 0) || (balance == 0)) begin
      next_word      = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      next_disparity = q_m[8] ? disparity + balance : disparity - balance;
    end else if (((disparity > 0) && (balance > 0)) || ((disparity < 0) && (balance < 0))) begin
      next_word      = {1'b1, q_m[8], ~q_m[7:0]}; // invert to pull back toward zero
      next_disparity = disparity + (q_m[8] ? 5'sd2 : 5'sd0) - balance;
    end else begin
      next_word      = {1'b0, q_m[8], q_m[7:0]};
      next_disparity = disparity - (q_m[8] ? 5'sd0 : 5'sd2) + balance;
    end
  end

  always_comb begin
    case (control)
      2'b00:   ctrl_word = 10'b1101010100;
      2'b01:   ctrl_word = 10'b0010101011;
      2'b10:   ctrl_word = 10'b0101010100;
      default: ctrl_word = 10'b1010101011;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      tmds      <= '0;
      disparity <= '0;
    end else if (!video_enable) begin
      tmds      <= ctrl_word;  // blanking
      disparity <= '0;
    end else begin
      tmds      <= next_word;
      disparity <= next_disparity;
    end
  end

endmodule
`default_nettype wire

/* hdl/car_video_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "car_video_settings.svh"

module car_video_top #(
  parameter int H_ACTIVE = `H_ACTIVE,
  parameter int H_FRONT  = `H_FRONT,
  parameter int H_SYNC   = `H_SYNC,
  parameter int H_BACK   = `H_BACK,
  parameter int V_ACTIVE = `V_ACTIVE,
  parameter int V_FRONT  = `V_FRONT,
  parameter int V_SYNC   = `V_SYNC,
  parameter int V_BACK   = `V_BACK
) (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire car_video_pkg::apb_addr_t paddr,
  input wire car_video_pkg::apb_data_t pwdata,
  output car_video_pkg::apb_data_t prdata,
  output logic pready,
  output logic pslverr,
  input wire [3:0] btn,
  output car_video_pkg::tmds_word_t tmds_red,
  output car_video_pkg::tmds_word_t tmds_green,
  output car_video_pkg::tmds_word_t tmds_blue
);
  import car_video_pkg::*;

  screen_count_t hcount, vcount;
  logic hsync, vsync, active, new_frame;
  world_coord_t camera_x, camera_y, car_x, car_y;
  world_coord_t body_w, body_h, wheel_r;
  color_idx_t bg_color;
  rgb_t pixel_rgb;
  logic hsync_d, vsync_d, active_d;  // aligned with pixel_rgb

  //////////////////////////////////////////////////////////////////////
  // timing, scene state, renderer
  video_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) i_video_timing (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .hcount(hcount), .vcount(vcount),
    .hsync(hsync), .vsync(vsync), .active(active), .new_frame(new_frame)
  );

  scene_regs i_scene_regs (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .btn(btn), .new_frame(new_frame),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .camera_x(camera_x), .camera_y(camera_y), .car_x(car_x), .car_y(car_y),
    .body_w(body_w), .body_h(body_h), .wheel_r(wheel_r), .bg_color(bg_color)
  );

  car_renderer #(
    .V_ACTIVE(V_ACTIVE)
  ) i_car_renderer (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync), .active(active),
    .camera_x(camera_x), .camera_y(camera_y), .car_x(car_x), .car_y(car_y),
    .body_w(body_w), .body_h(body_h), .wheel_r(wheel_r), .bg_color(bg_color),
    .pixel_rgb(pixel_rgb),
    .hsync_out(hsync_d), .vsync_out(vsync_d), .active_out(active_d)
  );

  //////////////////////////////////////////////////////////////////////
  // tmds channels, only blue carries sync
  tmds_encoder i_tmds_red (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .data(pixel_rgb.red), .control(2'b00), .video_enable(active_d),
    .tmds(tmds_red)
  );

  tmds_encoder i_tmds_green (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .data(pixel_rgb.green), .control(2'b00), .video_enable(active_d),
    .tmds(tmds_green)
  );

  tmds_encoder i_tmds_blue (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .data(pixel_rgb.blue), .control({vsync_d, hsync_d}), .video_enable(active_d),
    .tmds(tmds_blue)
  );

endmodule
`default_nettype wire

/* testbench/tb_car_video.sv */
`timescale 1ns/1ps
`default_nettype none
`include "car_video_settings.svh"

module tb_car_video;
  import car_video_pkg::*;

  // tiny frame, 44 cycles per line and 22 lines
  localparam int H_ACT = 32;
  localparam int H_FP = 4;
  localparam int H_SW = 4;
  localparam int H_BP = 4;
  localparam int V_ACT = 16;
  localparam int V_FP = 2;
  localparam int V_SW = 2;
  localparam int V_BP = 2;
  localparam int LINE = H_ACT + H_FP + H_SW + H_BP;
  localparam int FRAME = LINE * (V_ACT + V_FP + V_SW + V_BP);
  localparam int NF_POS = V_ACT * LINE + H_ACT;   // new_frame position
  localparam int LATENCY = 3;                     // renderer 2 + encoder 1
  localparam int HALF_PERIOD = 5;
  localparam int SETTLE_NS = 2;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_ROWS = 14;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 3 * FRAME + 2000;

  typedef struct packed {
    int cam_x;
    int cam_y;
    int car_x;
    int car_y;
    int body_w;
    int body_h;
    int wheel_r;
    logic [3:0] bg;
    logic [3:0] btn;
    int h;
    int v;
    logic [3:0] idx;
  } scene_row_t;

  logic clk_100mhz;
  logic sys_rst;
  logic psel;
  logic penable;
  logic pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic pready;
  logic pslverr;
  logic [3:0] btn;
  tmds_word_t tmds_red;
  tmds_word_t tmds_green;
  tmds_word_t tmds_blue;

  int cyc;            // posedges since reset release
  int mismatch_count;
  int other_errors;
  scene_row_t rows [NUM_ROWS];
  string row_names [NUM_ROWS];

  car_video_top #(
    .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
    .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP)
  ) i_car_video_top (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .btn(btn),
    .tmds_red(tmds_red), .tmds_green(tmds_green), .tmds_blue(tmds_blue)
  );

  always #(HALF_PERIOD) clk_100mhz = ~clk_100mhz;

  always @(posedge clk_100mhz) begin
    if (sys_rst) cyc <= 0;
    else cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // reference models

  function automatic logic [7:0] decode_tmds(input tmds_word_t w);
    logic [7:0] d;
    logic [7:0] b;
    d = w[9] ? ~w[7:0] : w[7:0];   // undo inversion
    b[0] = d[0];
    for (int i = 1; i < 8; i++) begin
      b[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return b;
  endfunction

  function automatic rgb_t palette_color(input color_idx_t idx);
    case (idx)
      COLOR_BLACK: return 24'h000000;
      COLOR_RED:   return 24'hFF0000;
      COLOR_BROWN: return 24'h8B4513;
      default:     return 24'h87CEEB;
    endcase
  endfunction

  function automatic tmds_word_t ctrl_word_for(input logic [1:0] c);
    case (c)
      2'b00:   return 10'b1101010100;
      2'b01:   return 10'b0010101011;
      2'b10:   return 10'b0101010100;
      default: return 10'b1010101011;
    endcase
  endfunction

  function automatic int pan_delta_x(input logic [3:0] b, input int frames);
    if (b[3]) return -frames * `CAMERA_STEP;
    if (b[2]) return frames * `CAMERA_STEP;
    return 0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus tasks, called on a falling edge

  task automatic bus_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
    psel = 1'b1;   // setup phase
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk_100mhz);
    penable = 1'b1;
    #(SETTLE_NS);
    rdata = prdata;
    err = pslverr;
    if (pready !== 1'b1) begin
      other_errors++;
      $display("pready was low during the access to address %h", addr);
    end
    @(negedge clk_100mhz);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused;
    bus_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data, output logic err);
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_checked(input apb_addr_t addr, input apb_data_t data);
    logic err;
    write_reg(addr, data, err);
    if (err) begin
      other_errors++;
      $display("write to address %h was refused with pslverr", addr);
    end
  endtask

  task automatic expect_read(input string name, input apb_addr_t addr, input apb_data_t exp);
    apb_data_t data;
    logic err;
    read_reg(addr, data, err);
    if (err) begin
      other_errors++;
      $display("read of %s was refused with pslverr", name);
    end
    if (data !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, data);
    end
  endtask

  task automatic write_then_read(input string name, input apb_addr_t addr,
                                 input apb_data_t wdata, input apb_data_t exp);
    write_checked(addr, wdata);
    expect_read(name, addr, exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // register block checks

  task automatic check_registers;
    apb_data_t data;
    logic err;
    expect_read("camera_x_reset", `ADDR_CAMERA_X, 32'(`RST_CAMERA_X));
    expect_read("camera_y_reset", `ADDR_CAMERA_Y, 32'(`RST_CAMERA_Y));
    expect_read("car_x_reset", `ADDR_CAR_X, 32'(`RST_CAR_X));
    expect_read("car_y_reset", `ADDR_CAR_Y, 32'(`RST_CAR_Y));
    expect_read("body_w_reset", `ADDR_BODY_W, 32'(`RST_BODY_W));
    expect_read("body_h_reset", `ADDR_BODY_H, 32'(`RST_BODY_H));
    expect_read("wheel_r_reset", `ADDR_WHEEL_R, 32'(`RST_WHEEL_R));
    expect_read("bg_color_reset", `ADDR_BG_COLOR, 32'(`RST_BG_COLOR));
    // 18 bit signed registers, bit 17 extends on readback
    write_then_read("camera_x_rw", `ADDR_CAMERA_X, 32'h0001_2345, 32'h0001_2345);
    write_then_read("camera_y_rw", `ADDR_CAMERA_Y, 32'hFFFF_FFF9, 32'hFFFF_FFF9);
    write_then_read("car_x_rw", `ADDR_CAR_X, 32'h0002_0000, 32'hFFFE_0000);
    write_then_read("car_y_rw", `ADDR_CAR_Y, 32'd1000, 32'd1000);
    write_then_read("body_w_rw", `ADDR_BODY_W, 32'hABC4_0123, 32'h0000_0123);
    write_then_read("body_h_rw", `ADDR_BODY_H, 32'd64, 32'd64);
    write_then_read("wheel_r_rw", `ADDR_WHEEL_R, 32'h0003_FFFF, 32'hFFFF_FFFF);
    write_then_read("bg_color_rw", `ADDR_BG_COLOR, 32'h0000_00A5, 32'h0000_0005);
    write_reg(8'h20, 32'h1234_5678, err);
    if (err !== 1'b1) begin
      other_errors++;
      $display("write to unmapped address 0x20 did not raise pslverr");
    end
    read_reg(8'h20, data, err);
    if (err !== 1'b1) begin
      other_errors++;
      $display("read of unmapped address 0x20 did not raise pslverr");
    end
    if (data !== 32'd0) begin
      mismatch_count++;
      $display("Mismatch unmapped_read: expected %h, actual %h", 32'd0, data);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // video checks

  task automatic load_scene(input scene_row_t r);
    write_checked(`ADDR_CAMERA_X, apb_data_t'(r.cam_x));
    write_checked(`ADDR_CAMERA_Y, apb_data_t'(r.cam_y));
    write_checked(`ADDR_CAR_X, apb_data_t'(r.car_x));
    write_checked(`ADDR_CAR_Y, apb_data_t'(r.car_y));
    write_checked(`ADDR_BODY_W, apb_data_t'(r.body_w));
    write_checked(`ADDR_BODY_H, apb_data_t'(r.body_h));
    write_checked(`ADDR_WHEEL_R, apb_data_t'(r.wheel_r));
    write_checked(`ADDR_BG_COLOR, {28'd0, r.bg});
  endtask

  // counts new_frame pulses seen with the buttons held
  task automatic hold_buttons(input logic [3:0] value, input int frames);
    int seen;
    seen = 0;
    btn = value;
    while (seen < frames) begin
      if (cyc % FRAME == NF_POS) seen++;
      @(negedge clk_100mhz);
    end
    btn = 4'b0000;
  endtask

  task automatic wait_for_pixel(input int h, input int v);
    int target;
    int start;
    target = v * LINE + h;
    start = cyc;
    while (!((cyc - LATENCY >= start) && ((cyc - LATENCY) % FRAME == target))) begin
      @(negedge clk_100mhz);
    end
  endtask

  task automatic check_pixel(input string name, input scene_row_t r);
    rgb_t exp_rgb;
    rgb_t got;
    logic hs;
    logic vs;
    tmds_word_t blank;
    wait_for_pixel(r.h, r.v);
    if (r.h < H_ACT && r.v < V_ACT) begin
      exp_rgb = palette_color(r.idx);
      got = {decode_tmds(tmds_red), decode_tmds(tmds_green), decode_tmds(tmds_blue)};
      if (got !== exp_rgb) begin
        mismatch_count++;
        $display("Mismatch %s: expected %h, actual %h", name, exp_rgb, got);
      end
    end else begin
      hs = (r.h >= H_ACT + H_FP) && (r.h < H_ACT + H_FP + H_SW);
      vs = (r.v >= V_ACT + V_FP) && (r.v < V_ACT + V_FP + V_SW);
      blank = ctrl_word_for(2'b00);
      if (tmds_red !== blank || tmds_green !== blank) begin
        mismatch_count++;
        $display("Mismatch %s red/green: expected %b, actual %b %b",
                 name, blank, tmds_red, tmds_green);
      end
      if (tmds_blue !== ctrl_word_for({vs, hs})) begin
        mismatch_count++;
        $display("Mismatch %s blue: expected %b, actual %b",
                 name, ctrl_word_for({vs, hs}), tmds_blue);
      end
    end
  endtask

  // write to camera_x lands on the same edge as a pan
  task automatic check_write_over_pan;
    logic err;
    while (cyc % FRAME != NF_POS - 1) @(negedge clk_100mhz);
    btn = 4'b0100;
    write_reg(`ADDR_CAMERA_X, 32'd77, err);
    btn = 4'b0000;
    expect_read("write_over_pan", `ADDR_CAMERA_X, 32'd77);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table: scene, buttons, pixel and expected palette index

  task automatic fill_table;
    row_names[0] = "reset_scene_bg";
    rows[0] = '{0, 0, 500, 300, 200, 100, 25, COLOR_LBLUE, 4'h0, 5, 3, COLOR_LBLUE};
    row_names[1] = "bg_red";
    rows[1] = '{0, 0, 8, 4, 12, 8, 5, COLOR_RED, 4'h0, 28, 1, COLOR_RED};
    row_names[2] = "bg_brown";
    rows[2] = '{0, 0, 8, 4, 12, 8, 5, COLOR_BROWN, 4'h0, 0, 0, COLOR_BROWN};
    row_names[3] = "body_interior";
    rows[3] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 14, 7, COLOR_RED};
    row_names[4] = "body_border";
    rows[4] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 14, 5, COLOR_BLACK};
    row_names[5] = "wheel_center";
    rows[5] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 20, 11, COLOR_BROWN};
    row_names[6] = "wheel_over_body";
    rows[6] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 11, 8, COLOR_BLACK};
    row_names[7] = "outside_car";
    rows[7] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 8, 3, COLOR_LBLUE};
    row_names[8] = "camera_y_offset";
    rows[8] = '{0, 2, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 14, 9, COLOR_RED};
    row_names[9] = "hblank";
    rows[9] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 33, 2, COLOR_BLACK};
    row_names[10] = "hsync";
    rows[10] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 37, 2, COLOR_BLACK};
    row_names[11] = "vsync";
    rows[11] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 5, 18, COLOR_BLACK};
    row_names[12] = "hvsync";
    rows[12] = '{0, 0, 8, 4, 12, 8, 5, COLOR_LBLUE, 4'h0, 37, 18, COLOR_BLACK};
    row_names[13] = "pan_body";   // body at world x 26 moves to column 11
    rows[13] = '{0, 0, 20, 4, 12, 8, 5, COLOR_BROWN, 4'h4, 11, 7, COLOR_RED};
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("mismatches=%0d other_errors=%0d", mismatch_count, other_errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clk_100mhz = 1'b0;
    sys_rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    btn = 4'b0000;
    mismatch_count = 0;
    other_errors = 0;
    fill_table();
    repeat (RESET_CYCLES) @(negedge clk_100mhz);
    if (tmds_red !== '0 || tmds_green !== '0 || tmds_blue !== '0) begin
      other_errors++;
      $display("tmds outputs were not all zero during reset");
    end
    sys_rst = 1'b0;
    if (prdata !== '0 || pslverr !== 1'b0) begin
      other_errors++;
      $display("prdata or pslverr not idle after reset");
    end
    check_registers();
    for (int i = 0; i < NUM_ROWS; i++) begin
      load_scene(rows[i]);
      if (rows[i].btn != 4'h0) begin
        hold_buttons(rows[i].btn, 3);
        expect_read({row_names[i], "_camera_x"}, `ADDR_CAMERA_X,
                    apb_data_t'(rows[i].cam_x + pan_delta_x(rows[i].btn, 3)));
      end
      check_pixel(row_names[i], rows[i]);
    end
    check_write_over_pan();
    $display("mismatches=%0d other_errors=%0d", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
`default_nettype wire

/* car_video.f */
+incdir+include
hdl/car_video_pkg.sv
hdl/video_timing.sv
hdl/scene_regs.sv
hdl/car_renderer.sv
hdl/tmds_encoder.sv
hdl/car_video_top.sv
testbench/tb_car_video.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_car_video -f car_video.f
out=$(./obj_dir/Vtb_car_video)
echo "$out"
if echo "$out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
exit 1
